//--- hdl/cpu_pkg.sv
package cpu_pkg;

    typedef logic [31:0] word_t;     // Data word or byte address
    typedef logic [4:0]  reg_addr_t;
    typedef logic [7:0]  rom_addr_t; // ROM word address

    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B     // LUI
    } alu_op_t;

    typedef struct packed {
        alu_op_t alu_op;
        logic    alu_src_imm;
        logic    mem_read;
        logic    mem_write;
        logic    reg_write;
        logic    branch;
        logic    branch_ne;  // BNE when set, BEQ otherwise
    } ctrl_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } if_id_t;

    typedef struct packed {
        logic      valid;
        ctrl_t     ctrl;
        word_t     pc;
        word_t     rs1_value;
        word_t     rs2_value;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     imm;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      mem_read;
        logic      mem_write;
        logic      reg_write;
        reg_addr_t rd;
        word_t     result;      // ALU result or byte address
        word_t     store_value;
    } ex_mem_t;

    typedef struct packed {
        logic      reg_write;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

    typedef struct packed {
        word_t addr;   // Word address into the RAM
        word_t wdata;
        logic  we;
    } mem_req_t;

endpackage

//--- hdl/fetch.sv
`timescale 1ns/1ps

module fetch (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               enable,
    input  logic               stall,
    input  logic               load_stall,
    input  logic               branch_taken,
    input  cpu_pkg::word_t     branch_target,
    input  cpu_pkg::word_t     rom_data,
    output cpu_pkg::rom_addr_t rom_address,
    output cpu_pkg::if_id_t    if_id
);
    import cpu_pkg::*;

    word_t pc;

    assign rom_address = pc[2 +: $bits(rom_addr_t)]; // ROM is word addressed

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc    <= '0;
            if_id <= '0;
        end else if (enable && !stall) begin
            if (branch_taken) begin
                pc          <= branch_target;
                if_id.valid <= 1'b0;   // Wrong-path fetch
            end else if (!load_stall) begin
                pc          <= pc + 32'd4;
                if_id.valid <= 1'b1;
                if_id.pc    <= pc;
                if_id.instr <= rom_data;
            end
            // Load-use stall keeps PC and if_id as they are
        end
    end

endmodule

//--- hdl/decode.sv
`timescale 1ns/1ps

module decode (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               enable,
    input  logic               stall,
    input  logic               branch_taken,
    input  cpu_pkg::if_id_t    if_id,
    input  cpu_pkg::word_t     rs1_value,
    input  cpu_pkg::word_t     rs2_value,
    input  cpu_pkg::reg_addr_t ex_rd,
    input  logic               ex_mem_read,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2,
    output logic               load_stall,
    output cpu_pkg::id_ex_t    id_ex
);
    import cpu_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    ctrl_t      ctrl;
    word_t      imm;
    logic       uses_rs1;
    logic       uses_rs2;

    assign opcode = if_id.instr[6:0];
    assign funct3 = if_id.instr[14:12];
    assign rs1    = if_id.instr[19:15];
    assign rs2    = if_id.instr[24:20];

    always_comb begin
        ctrl     = '0;
        imm      = '0;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b0;
        case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                uses_rs2       = 1'b1;
                case (funct3)
                    3'b000:  ctrl.alu_op = if_id.instr[30] ? ALU_SUB : ALU_ADD;
                    3'b100:  ctrl.alu_op = ALU_XOR;
                    3'b110:  ctrl.alu_op = ALU_OR;
                    3'b111:  ctrl.alu_op = ALU_AND;
                    default: ctrl.reg_write = 1'b0; // Outside the subset
                endcase
            end
            OP_IMM: begin   // ADDI
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
            end
            OP_LUI: begin
                ctrl.reg_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_op      = ALU_PASS_B;
                uses_rs1         = 1'b0;
                imm = {if_id.instr[31:12], 12'b0};
            end
            OP_LOAD: begin
                ctrl.reg_write   = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                imm = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
            end
            OP_STORE: begin
                ctrl.mem_write   = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                uses_rs2         = 1'b1;
                imm = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
            end
            OP_BRANCH: begin
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                uses_rs2       = 1'b1;
                imm = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
                       if_id.instr[30:25], if_id.instr[11:8], 1'b0};
            end
            default: uses_rs1 = 1'b0;   // Treated as a NOP
        endcase
    end

    // Load in execute feeding this instruction
    assign load_stall = if_id.valid && ex_mem_read && (ex_rd != '0)
                     && ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            id_ex <= '0;
        end else if (enable && !stall) begin
            if (branch_taken || load_stall || !if_id.valid) begin
                id_ex.valid <= 1'b0;
                id_ex.ctrl  <= '0;     // Bubble must not look like a load
            end else begin
                id_ex.valid     <= 1'b1;
                id_ex.ctrl      <= ctrl;
                id_ex.pc        <= if_id.pc;
                id_ex.rs1_value <= rs1_value;
                id_ex.rs2_value <= rs2_value;
                id_ex.rs1       <= rs1;
                id_ex.rs2       <= rs2;
                id_ex.rd        <= if_id.instr[11:7];
                id_ex.imm       <= imm;
            end
        end
    end

endmodule

//--- hdl/register_bank.sv
`timescale 1ns/1ps

module register_bank (
    input  logic               clock,
    input  logic               rst_n,
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::wb_t       wb,
    output cpu_pkg::word_t     rs1_value,
    output cpu_pkg::word_t     rs2_value
);
    import cpu_pkg::*;

    word_t regs [1:31];   // x0 is not stored

    // Same-cycle write is seen by the read
    assign rs1_value = (rs1 == '0) ? '0 :
                       (wb.reg_write && wb.rd == rs1) ? wb.data : regs[rs1];
    assign rs2_value = (rs2 == '0) ? '0 :
                       (wb.reg_write && wb.rd == rs2) ? wb.data : regs[rs2];

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.reg_write && wb.rd != '0) begin
            regs[wb.rd] <= wb.data;
        end
    end

endmodule

//--- hdl/execute.sv
`timescale 1ns/1ps

module execute (
    input  logic             clock,
    input  logic             rst_n,
    input  logic             enable,
    input  logic             stall,
    input  cpu_pkg::id_ex_t  id_ex,
    input  cpu_pkg::ex_mem_t ex_mem_fwd,
    input  cpu_pkg::wb_t     wb,
    output cpu_pkg::ex_mem_t ex_mem,
    output logic             branch_taken,
    output cpu_pkg::word_t   branch_target
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_b;
    word_t alu_result;

    // Memory stage is younger than writeback, so it is checked first
    function automatic word_t forward(reg_addr_t rs, word_t value, ex_mem_t mem_stage,
                                      wb_t wb_stage);
        if (rs == '0) begin
            return value;
        end
        if (mem_stage.valid && mem_stage.reg_write && !mem_stage.mem_read
            && mem_stage.rd == rs) begin
            return mem_stage.result;   // Loads are covered by the decode stall
        end
        if (wb_stage.reg_write && wb_stage.rd == rs) begin
            return wb_stage.data;
        end
        return value;
    endfunction

    assign op_a  = forward(id_ex.rs1, id_ex.rs1_value, ex_mem_fwd, wb);
    assign op_b  = forward(id_ex.rs2, id_ex.rs2_value, ex_mem_fwd, wb);
    assign alu_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b;

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_result = op_a - alu_b;
            ALU_AND:    alu_result = op_a & alu_b;
            ALU_OR:     alu_result = op_a | alu_b;
            ALU_XOR:    alu_result = op_a ^ alu_b;
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = op_a + alu_b;  // ADD, ADDI and addresses
        endcase
    end

    assign branch_taken  = id_ex.valid && id_ex.ctrl.branch
                        && ((op_a == op_b) != id_ex.ctrl.branch_ne);
    assign branch_target = id_ex.pc + id_ex.imm;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ex_mem <= '0;
        end else if (enable && !stall) begin
            ex_mem.valid       <= id_ex.valid;
            ex_mem.mem_read    <= id_ex.valid && id_ex.ctrl.mem_read;
            ex_mem.mem_write   <= id_ex.valid && id_ex.ctrl.mem_write;
            ex_mem.reg_write   <= id_ex.valid && id_ex.ctrl.reg_write;
            ex_mem.rd          <= id_ex.rd;
            ex_mem.result      <= alu_result;
            ex_mem.store_value <= op_b;
        end
    end

endmodule

//--- hdl/memory.sv
`timescale 1ns/1ps

module memory #(
    parameter int             RAM_WORDS = 64,
    parameter cpu_pkg::word_t IO_ADDR   = 32'h100
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               enable,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  logic               ram_ack,
    input  cpu_pkg::word_t     rdata,
    output logic               ram_req,
    output cpu_pkg::mem_req_t  mem_req,
    output logic               stall,
    output cpu_pkg::word_t     io_data,
    output logic               io_valid,
    output cpu_pkg::wb_t       wb
);
    import cpu_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);

    typedef enum logic [1:0] {IDLE, WAIT_ACK, WAIT_RELEASE} state_t;

    state_t state;
    word_t  load_data;
    logic   is_io;
    logic   ram_access;
    logic   io_store;

    assign is_io      = (ex_mem.result == IO_ADDR);
    assign ram_access = ex_mem.valid && (ex_mem.mem_read || ex_mem.mem_write) && !is_io;
    assign io_store   = ex_mem.valid && ex_mem.mem_write && is_io;

    assign mem_req.addr  = word_t'(ex_mem.result[2 +: AW]); // Wrapped word address
    assign mem_req.wdata = ex_mem.store_value;
    assign mem_req.we    = ex_mem.mem_write;

    // Released only once ack has dropped again
    assign stall = ram_access && !(state == WAIT_RELEASE && !ram_ack);

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            ram_req <= 1'b0;
        end else if (enable) begin
            case (state)
                IDLE: if (ram_access) begin
                    ram_req <= 1'b1;
                    state   <= WAIT_ACK;
                end
                WAIT_ACK: if (ram_ack) begin
                    ram_req <= 1'b0;
                    state   <= WAIT_RELEASE;
                end
                default: if (!ram_ack) state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (enable && state == WAIT_ACK && ram_ack) load_data <= rdata;
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            wb       <= '0;
            io_data  <= '0;
            io_valid <= 1'b0;
        end else begin
            io_valid <= enable && !stall && io_store;  // One-cycle pulse
            if (enable && !stall) begin
                wb.reg_write <= ex_mem.valid && ex_mem.reg_write;
                wb.rd        <= ex_mem.rd;
                wb.data      <= !ex_mem.mem_read ? ex_mem.result :
                                is_io ? io_data : load_data;
                if (io_store) io_data <= ex_mem.store_value;
            end
        end
    end

endmodule

//--- hdl/ram.sv
`timescale 1ns/1ps

module ram #(
    parameter int RAM_WORDS = 64,
    parameter int RAM_WAIT  = 2
) (
    input  logic              clock,
    input  logic              rst_n,
    input  logic              ram_req,
    input  cpu_pkg::mem_req_t mem_req,
    output logic              ram_ack,
    output cpu_pkg::word_t    rdata
);
    import cpu_pkg::*;

    localparam int AW = $clog2(RAM_WORDS);
    localparam int CW = (RAM_WAIT > 1) ? $clog2(RAM_WAIT) : 1;

    word_t         mem [RAM_WORDS];
    logic [CW-1:0] wait_count;
    logic [AW-1:0] index;
    logic          fire;

    assign index = mem_req.addr[AW-1:0];
    // Last wait cycle, access happens as ack rises
    assign fire  = ram_req && !ram_ack && (wait_count == CW'(RAM_WAIT - 1));

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            ram_ack    <= 1'b0;
            wait_count <= '0;
        end else if (fire) begin
            ram_ack    <= 1'b1;
            wait_count <= '0;
        end else if (ram_req && !ram_ack) begin
            wait_count <= wait_count + 1'b1;
        end else if (!ram_req) begin
            ram_ack <= 1'b0;   // Requester let go
        end
    end

    always_ff @(posedge clock) begin
        if (fire) begin
            if (mem_req.we) mem[index] <= mem_req.wdata;
            else rdata <= mem[index];
        end
    end

endmodule

//--- hdl/cpu.sv
`timescale 1ns/1ps

module cpu #(
    parameter int             RAM_WORDS = 64,
    parameter int             RAM_WAIT  = 2,
    parameter cpu_pkg::word_t IO_ADDR   = 32'h100
) (
    input  logic               clock,
    input  logic               rst_n,
    input  logic               enable,
    input  cpu_pkg::word_t     rom_data,
    output cpu_pkg::rom_addr_t rom_address,
    output logic [5:0]         led,
    output cpu_pkg::word_t     io_data,
    output logic               io_valid
);
    import cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    wb_t       wb;
    mem_req_t  mem_req;
    reg_addr_t rs1, rs2;
    word_t     rs1_value, rs2_value;
    word_t     branch_target, rdata;
    logic      branch_taken, load_stall, stall;
    logic      ram_req, ram_ack;

    assign led = ~io_data[5:0];   // Active-low LED board

    fetch i_fetch (
        .clock, .rst_n, .enable, .stall, .load_stall, .branch_taken,
        .branch_target, .rom_data, .rom_address, .if_id
    );

    decode i_decode (
        .clock, .rst_n, .enable, .stall, .branch_taken, .if_id,
        .rs1_value, .rs2_value,
        .ex_rd(id_ex.rd), .ex_mem_read(id_ex.ctrl.mem_read),
        .rs1, .rs2, .load_stall, .id_ex
    );

    register_bank i_register_bank (
        .clock, .rst_n, .rs1, .rs2, .wb, .rs1_value, .rs2_value
    );

    execute i_execute (
        .clock, .rst_n, .enable, .stall, .id_ex,
        .ex_mem_fwd(ex_mem), .wb, .ex_mem, .branch_taken, .branch_target
    );

    memory #(.RAM_WORDS(RAM_WORDS), .IO_ADDR(IO_ADDR)) i_memory (
        .clock, .rst_n, .enable, .ex_mem, .ram_ack, .rdata,
        .ram_req, .mem_req, .stall, .io_data, .io_valid, .wb
    );

    ram #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT)) i_ram (
        .clock, .rst_n, .ram_req, .mem_req, .ram_ack, .rdata
    );

endmodule

//--- dv/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;
    import cpu_pkg::*;

    localparam int         RAM_WORDS = 64;
    localparam int         RAM_WAIT  = 2;
    localparam word_t      IO_ADDR   = 32'h100;
    localparam int         NUM_TESTS = 5;
    localparam word_t      SELF_LOOP = 32'h0000_0063;  // beq x0, x0, 0
    localparam logic [2:0] F_ADD     = 3'b000;
    localparam logic [2:0] F_XOR     = 3'b100;
    localparam logic [2:0] F_OR      = 3'b110;
    localparam logic [2:0] F_AND     = 3'b111;

    logic       clock  = 1'b0;
    logic       rst_n  = 1'b0;
    logic       enable = 1'b1;
    word_t      rom_data;
    rom_addr_t  rom_address;
    logic [5:0] led;
    word_t      io_data;
    logic       io_valid;

    word_t     rom [256];
    word_t     prog_mem [NUM_TESTS][256];
    int        prog_len [NUM_TESTS];
    string     test_name [NUM_TESTS] = '{"alu_forwarding", "ram_load_store", "branches",
                                         "enable_gating", "random_program"};
    word_t     expected [$];
    word_t     last_out = '0;
    integer    seed = 32'he145;
    int        limit_cycles = 0;
    int        cur_test = 0;
    int        test_errors = 0;
    int        seen = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    int        span_left = 0;
    logic      active = 1'b0;
    logic      gate = 1'b0;
    logic      at_end = 1'b0;
    logic      left_end = 1'b0;
    logic      end_seen = 1'b0;
    rom_addr_t end_idx = '0;

    always #20 clock = ~clock;

    assign rom_data = rom[rom_address];  // Combinational ROM

    cpu #(.RAM_WORDS(RAM_WORDS), .RAM_WAIT(RAM_WAIT), .IO_ADDR(IO_ADDR)) i_cpu (
        .clock, .rst_n, .enable, .rom_data, .rom_address, .led, .io_data, .io_valid
    );

    function automatic word_t reg_op(logic [2:0] f3, logic alt, reg_addr_t rd,
                                     reg_addr_t rs1, reg_addr_t rs2);
        return {1'b0, alt, 5'b0, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic word_t addi(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, OP_IMM};
    endfunction

    function automatic word_t lui(reg_addr_t rd, logic [19:0] imm);
        return {imm, rd, OP_LUI};
    endfunction

    function automatic word_t lw(reg_addr_t rd, reg_addr_t rs1, logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, OP_LOAD};
    endfunction

    function automatic word_t sw(reg_addr_t rs2, reg_addr_t rs1, logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t branch(logic ne, reg_addr_t rs1, reg_addr_t rs2, int offset);
        logic [12:0] off;
        off = 13'(offset);  // Byte offset
        return {off[12], off[10:5], rs2, rs1, 2'b00, ne, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic int pick(int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    task automatic put(int t, word_t instr);
        prog_mem[t][prog_len[t]] = instr;
        prog_len[t]++;
    endtask

    task automatic show(int t, reg_addr_t r);
        put(t, sw(r, 5'd0, IO_ADDR[11:0]));
    endtask

    // Two fillers keep older branches away from the final loop
    task automatic close_program(int t);
        put(t, addi(5'd0, 5'd0, 12'h000));
        put(t, addi(5'd0, 5'd0, 12'h000));
        put(t, SELF_LOOP);
    endtask

    task automatic build_alu(int t);
        put(t, addi(1, 0, 12'h035));
        put(t, addi(2, 1, 12'h01c));          // From memory stage
        put(t, reg_op(F_ADD, 1'b0, 3, 1, 2)); // One from each later stage
        show(t, 3);
        put(t, reg_op(F_ADD, 1'b1, 4, 3, 1));
        show(t, 4);
        put(t, reg_op(F_AND, 1'b0, 5, 4, 3));
        put(t, reg_op(F_OR, 1'b0, 6, 5, 4));
        show(t, 5);
        show(t, 6);
        put(t, reg_op(F_XOR, 1'b0, 7, 6, 2));
        show(t, 7);
        put(t, lui(8, 20'habcde));
        put(t, addi(8, 8, 12'h123));
        show(t, 8);
        put(t, addi(9, 0, 12'hfff));
        put(t, reg_op(F_XOR, 1'b0, 10, 9, 8));
        show(t, 10);
        show(t, 2);
        close_program(t);
    endtask

    task automatic build_ram(int t);
        put(t, addi(1, 0, 12'h011));
        put(t, lui(2, 20'h12345));
        put(t, addi(2, 2, 12'h678));
        put(t, sw(1, 0, 12'h000));
        put(t, sw(2, 0, 12'h004));
        put(t, addi(3, 0, 12'h040));
        put(t, sw(2, 3, 12'h008));            // Base from memory stage
        put(t, lw(4, 0, 12'h000));
        put(t, reg_op(F_ADD, 1'b0, 5, 4, 1)); // Load-use
        show(t, 5);
        put(t, lw(6, 0, 12'h004));
        put(t, lw(7, 3, 12'h008));
        put(t, reg_op(F_XOR, 1'b0, 8, 6, 7));
        show(t, 8);
        show(t, 6);
        put(t, reg_op(F_ADD, 1'b0, 9, 5, 6));
        put(t, sw(9, 3, 12'h00c));
        put(t, lw(10, 3, 12'h00c));
        show(t, 10);                          // Store data straight from a load
        put(t, addi(11, 0, 12'h0fc));         // Last RAM word
        put(t, sw(1, 11, 12'h000));
        put(t, lw(12, 11, 12'h000));
        put(t, addi(12, 12, 12'h001));
        show(t, 12);
        put(t, lw(13, 0, 12'h104));           // Wraps onto word 1
        show(t, 13);
        close_program(t);
    endtask

    task automatic build_branch(int t);
        int loop_at;
        put(t, addi(1, 0, 12'h000));
        put(t, addi(2, 0, 12'h005));
        put(t, addi(3, 0, 12'h000));
        loop_at = prog_len[t];
        put(t, addi(1, 1, 12'h001));
        put(t, reg_op(F_ADD, 1'b0, 3, 3, 1));
        put(t, branch(1'b1, 1, 2, (loop_at - prog_len[t]) * 4));
        show(t, 3);
        put(t, branch(1'b0, 1, 2, 12));       // Taken, skips two
        put(t, addi(4, 0, 12'h7ff));
        show(t, 4);
        put(t, addi(5, 0, 12'h022));
        show(t, 5);
        put(t, branch(1'b1, 1, 2, 8));        // Not taken
        put(t, addi(5, 5, 12'h001));
        show(t, 5);
        put(t, branch(1'b0, 1, 3, 8));        // Not taken
        put(t, addi(6, 0, 12'h033));
        show(t, 6);
        put(t, branch(1'b1, 1, 3, 12));
        show(t, 1);
        show(t, 2);
        show(t, 3);
        close_program(t);
    endtask

    task automatic build_random(int t);
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        int        kind;
        for (int i = 0; i < 40; i++) begin
            rd   = reg_addr_t'(1 + pick(15));
            rs1  = reg_addr_t'(pick(16));
            rs2  = reg_addr_t'(pick(16));
            kind = pick(7);
            case (kind)
                0:       put(t, reg_op(F_ADD, 1'b0, rd, rs1, rs2));
                1:       put(t, reg_op(F_ADD, 1'b1, rd, rs1, rs2));
                2:       put(t, reg_op(F_XOR, 1'b0, rd, rs1, rs2));
                3:       put(t, reg_op(F_OR, 1'b0, rd, rs1, rs2));
                4:       put(t, reg_op(F_AND, 1'b0, rd, rs1, rs2));
                5:       put(t, addi(rd, rs1, 12'(pick(4096))));
                default: put(t, lui(rd, 20'(pick(1 << 20))));
            endcase
            if (i % 5 == 4) begin
                show(t, rd);   // Sixth slot of each group
            end
        end
        close_program(t);
    endtask

    // Architectural model, collects every store to IO_ADDR in order
    function automatic void model_outputs(int t);
        word_t              regs [32];
        word_t              dmem [RAM_WORDS];
        word_t              ins, a, b, res, addr;
        logic signed [12:0] boff;
        int                 pc;
        int                 steps;
        logic               writes;
        expected.delete();
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        for (int i = 0; i < RAM_WORDS; i++) begin
            dmem[i] = '0;
        end
        pc    = 0;
        steps = 0;
        while (prog_mem[t][pc] != SELF_LOOP && steps < 10000) begin
            ins    = prog_mem[t][pc];
            a      = regs[ins[19:15]];
            b      = regs[ins[24:20]];
            res    = '0;
            writes = 1'b1;
            pc++;
            case (ins[6:0])
                OP_REG: begin
                    case (ins[14:12])
                        F_ADD:   res = ins[30] ? a - b : a + b;
                        F_XOR:   res = a ^ b;
                        F_OR:    res = a | b;
                        default: res = a & b;
                    endcase
                end
                OP_IMM: res = a + {{20{ins[31]}}, ins[31:20]};
                OP_LUI: res = {ins[31:12], 12'b0};
                OP_LOAD: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]};
                    res  = dmem[(addr >> 2) % RAM_WORDS];
                end
                OP_STORE: begin
                    writes = 1'b0;
                    addr   = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    if (addr == IO_ADDR) begin
                        expected.push_back(b);
                    end else begin
                        dmem[(addr >> 2) % RAM_WORDS] = b;
                    end
                end
                OP_BRANCH: begin
                    writes = 1'b0;
                    boff   = {ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                    if ((a == b) != ins[12]) begin
                        pc = pc - 1 + boff / 4;
                    end
                end
                default: writes = 1'b0;
            endcase
            if (writes && ins[11:7] != 5'd0) begin
                regs[ins[11:7]] = res;
            end
            steps++;
        end
    endfunction

    task automatic check_value(int t, string what, word_t exp, word_t act);
        if (exp !== act) begin
            $display("MISMATCH %s %s: expected %h, actual %h", test_name[t], what, exp, act);
            test_errors++;
        end
    endtask

    // Random enable spans, only while gating is on
    always @(negedge clock) begin
        if (!gate) begin
            enable = 1'b1;
        end else if (span_left > 0) begin
            span_left--;
        end else begin
            enable    = ~enable;
            span_left = pick(5);
        end
    end

    always @(negedge clock) begin
        if (active) begin
            if (io_valid) begin
                if (seen < expected.size()) begin
                    check_value(cur_test, $sformatf("output %0d", seen), expected[seen], io_data);
                    last_out = expected[seen];
                end else begin
                    $display("%s: unexpected output %h after the last expected store",
                             test_name[cur_test], io_data);
                    test_errors++;
                end
                seen++;
            end
            // Active-low LEDs follow the last stored value
            check_value(cur_test, "led", {26'b0, ~last_out[5:0]}, {26'b0, led});
            // Back at the final loop after leaving it means it has executed
            if (rom_address == end_idx) begin
                if (left_end) end_seen = 1'b1;
                at_end = 1'b1;
            end else if (at_end) begin
                left_end = 1'b1;
            end
        end
    end

    task automatic run_test(int t);
        @(negedge clock);
        rst_n = 1'b0;
        gate  = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = (i < prog_len[t]) ? prog_mem[t][i] : addi(5'd0, 5'd0, 12'(i));
        end
        model_outputs(t);
        test_errors = 0;
        seen        = 0;
        last_out    = '0;
        at_end      = 1'b0;
        left_end    = 1'b0;
        end_seen    = 1'b0;
        end_idx     = rom_addr_t'(prog_len[t] - 1);
        repeat (2) @(negedge clock);
        check_value(t, "led after reset", 32'h3f, {26'b0, led});
        rst_n  = 1'b1;
        gate   = (t == 3);
        active = 1'b1;
        wait (end_seen);
        active = 1'b0;
        if (seen < expected.size()) begin
            $display("%s: too few outputs, %0d of %0d stores seen", test_name[t], seen,
                     expected.size());
            test_errors++;
        end
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: ok, %0d outputs", test_name[t], seen);
        end else begin
            fail_count++;
            $display("%s: failed with %0d errors", test_name[t], test_errors);
        end
    endtask

    initial begin
        int total;
        total = 0;
        for (int i = 0; i < 256; i++) begin
            rom[i] = addi(5'd0, 5'd0, 12'(i));
        end
        for (int t = 0; t < NUM_TESTS; t++) begin
            prog_len[t] = 0;
        end
        build_alu(0);
        build_ram(1);
        build_branch(2);
        build_alu(3);        // Same program, run with enable gating
        build_random(4);
        for (int t = 0; t < NUM_TESTS; t++) begin
            total += 10 * prog_len[t] * (RAM_WAIT + 4);
        end
        limit_cycles = total;
        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_test = t;
            run_test(t);
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clock);
        $display("Watchdog expired after %0d cycles in %s, the program never reached its end",
                 limit_cycles, test_name[cur_test]);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- flist.f
hdl/cpu_pkg.sv
hdl/fetch.sv
hdl/decode.sv
hdl/register_bank.sv
hdl/execute.sv
hdl/memory.sv
hdl/ram.sv
hdl/cpu.sv
dv/cpu_tb.sv

//--- Bender.yml
package:
  name: cpu

sources:
  - hdl/cpu_pkg.sv
  - hdl/fetch.sv
  - hdl/decode.sv
  - hdl/register_bank.sv
  - hdl/execute.sv
  - hdl/memory.sv
  - hdl/ram.sv
  - hdl/cpu.sv
  - target: test
    files:
      - dv/cpu_tb.sv
